// ==== dispatch_stage.sv ====
`default_nettype none

`include "mapper_defines.svh"

module dispatch_stage import mapper_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      s2_valid,
    input  wire logic      s2_op1_rdy,
    input  wire logic      s2_op2_rdy,
    input  wire phys_tag_t s2_op1_tag,
    input  wire phys_tag_t s2_op2_tag,
    input  wire xlen_t     s2_op1_val,
    input  wire xlen_t     s2_op2_val,
    input  wire uop_t      s2_uop,
    input  wire logic      s2_eoi,
    input  wire phys_tag_t s2_dest_tag,
    input  wire phys_tag_t s2_old_tag,
    input  wire arch_reg_t s2_dest_arch,
    input  wire logic      s2_has_dest,
    input  wire xlen_t     s2_imm,
    input  wire logic      s2_use_imm,
    input  wire xlen_t     s2_pc,
    input  wire logic      s2_except,
    input  wire logic      rob_full,
    input  wire rob_idx_t  rob_entry_in,
    output logic           hold,
    output logic           disp_valid,
    output uop_t           uop_out,
    output logic           eoi_out,
    output logic           op1_rdy_out,
    output logic           op2_rdy_out,
    output phys_tag_t      op1_tag_out,
    output phys_tag_t      op2_tag_out,
    output xlen_t          op1_val_out,
    output xlen_t          op2_val_out,
    output phys_tag_t      dest_tag_out,
    output xlen_t          pc_out,
    output rob_idx_t       rob_entry_out,
    output logic           alloc_rob,
    output arch_reg_t      dest_arch_out,
    output phys_tag_t      dest_oldtag_out,
    output logic           except_out
);

    // a waiting micro-op and no ROB space freezes the whole pipe
    assign hold = disp_valid && rob_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            disp_valid <= 1'b0;
            alloc_rob  <= 1'b0;
        end else if (!hold) begin
            disp_valid <= s2_valid;
            alloc_rob  <= s2_valid && (s2_has_dest || s2_except);  // ROB tracks these only
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && s2_valid) begin
            uop_out         <= s2_uop;
            eoi_out         <= s2_eoi;
            op1_rdy_out     <= s2_op1_rdy;
            op1_tag_out     <= s2_op1_tag;
            op1_val_out     <= s2_op1_val;
            // immediate takes the place of source 2 and is always ready
            op2_rdy_out     <= s2_use_imm || s2_op2_rdy;
            op2_tag_out     <= s2_use_imm ? '0 : s2_op2_tag;
            op2_val_out     <= s2_use_imm ? s2_imm : s2_op2_val;
            dest_tag_out    <= s2_dest_tag;
            pc_out          <= s2_pc;
            rob_entry_out   <= rob_entry_in;    // ROB write pointer at capture
            dest_arch_out   <= s2_dest_arch;
            dest_oldtag_out <= s2_old_tag;      // freed when this micro-op commits
            except_out      <= s2_except;
        end
    end

endmodule

`default_nettype wire

// ==== free_list.sv ====
`default_nettype none

`include "mapper_defines.svh"

module free_list import mapper_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      pop,          // rename took free_tag
    input  wire logic      push,         // commit hands a tag back
    input  wire phys_tag_t push_tag,
    output phys_tag_t      free_tag,
    output logic           free_empty
);

    phys_tag_t tags [`MAPPER_PHYS_REGS];
    phys_tag_t head;                     // next tag handed out
    phys_tag_t tail;                     // next slot for a returned tag
    fl_count_t count;

    logic do_pop;
    logic do_push;
    logic full;

    assign free_tag   = tags[head];
    assign free_empty = (count == '0);
    assign full       = (count == fl_count_t'(`MAPPER_PHYS_REGS));

    // an empty list gives nothing, a full one only takes a tag while one leaves
    assign do_pop  = pop && !free_empty;
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (reset) begin
            // everything above the identity map starts out free, lowest first
            for (int i = 0; i < `MAPPER_PHYS_REGS - `MAPPER_ARCH_REGS; i++) begin
                tags[i] <= phys_tag_t'(i + `MAPPER_ARCH_REGS);
            end
            head  <= '0;
            tail  <= phys_tag_t'(`MAPPER_PHYS_REGS - `MAPPER_ARCH_REGS);
            count <= fl_count_t'(`MAPPER_PHYS_REGS - `MAPPER_ARCH_REGS);
        end else begin
            if (do_push) begin
                tags[tail] <= push_tag;
                tail       <= tail + 1'b1;      // wraps at the end of the buffer
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none, or one in and one out
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mapper_defines.svh ====
`ifndef MAPPER_DEFINES_SVH
`define MAPPER_DEFINES_SVH

// register file sizes
`define MAPPER_ARCH_REGS 32
`define MAPPER_PHYS_REGS 64    // must stay a power of two, free list pointers wrap

`define MAPPER_ROB_SIZE 32     // reorder buffer entries

`define MAPPER_XLEN 32         // data word
`define MAPPER_UOP_BITS 5      // micro-op code

// index widths follow from the counts
`define MAPPER_ARCH_BITS $clog2(`MAPPER_ARCH_REGS)
`define MAPPER_PHYS_BITS $clog2(`MAPPER_PHYS_REGS)
`define MAPPER_ROB_BITS $clog2(`MAPPER_ROB_SIZE)

`endif

// ==== mapper_pkg.sv ====
`default_nettype none

`include "mapper_defines.svh"

package mapper_pkg;

    typedef logic [`MAPPER_ARCH_BITS-1:0] arch_reg_t;   // architectural register index
    typedef logic [`MAPPER_PHYS_BITS-1:0] phys_tag_t;   // physical register tag
    typedef logic [`MAPPER_ROB_BITS-1:0]  rob_idx_t;
    typedef logic [`MAPPER_UOP_BITS-1:0]  uop_t;
    typedef logic [`MAPPER_XLEN-1:0]      xlen_t;

    // free list occupancy, one bit wider than a tag so a full list fits
    typedef logic [`MAPPER_PHYS_BITS:0]   fl_count_t;

endpackage

`default_nettype wire

// ==== mapper_top.sv ====
`default_nettype none

`include "mapper_defines.svh"

module mapper_top import mapper_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    // incoming micro-op
    input  wire logic      uop_valid,
    input  wire uop_t      uop,
    input  wire logic      eoi,
    input  wire arch_reg_t src1_arch,
    input  wire arch_reg_t src2_arch,
    input  wire arch_reg_t dest_arch,
    input  wire logic      has_dest,
    input  wire xlen_t     imm,
    input  wire logic      use_imm,
    input  wire xlen_t     pc,
    input  wire logic      except,
    // writeback and commit
    input  wire logic      wb_valid,
    input  wire phys_tag_t wb_tag,
    input  wire xlen_t     wb_val,
    input  wire logic      commit_valid,
    input  wire phys_tag_t commit_tag,
    // ROB status
    input  wire logic      rob_full,
    input  wire rob_idx_t  rob_entry_in,
    output logic           stall,
    // to reservation stations and ROB
    output logic           disp_valid,
    output uop_t           uop_out,
    output logic           eoi_out,
    output logic           op1_rdy_out,
    output logic           op2_rdy_out,
    output phys_tag_t      op1_tag_out,
    output phys_tag_t      op2_tag_out,
    output xlen_t          op1_val_out,
    output xlen_t          op2_val_out,
    output phys_tag_t      dest_tag_out,
    output xlen_t          pc_out,
    output rob_idx_t       rob_entry_out,
    output logic           alloc_rob,
    output arch_reg_t      dest_arch_out,
    output phys_tag_t      dest_oldtag_out,
    output logic           except_out
);

    phys_tag_t free_tag;
    logic      free_empty;
    logic      pop;
    logic      hold;
    logic      alloc_valid;
    phys_tag_t alloc_tag;

    // rename -> operand read
    logic      s1_valid, s1_eoi, s1_has_dest, s1_use_imm, s1_except;
    uop_t      s1_uop;
    phys_tag_t s1_src1_tag, s1_src2_tag, s1_dest_tag, s1_old_tag;
    arch_reg_t s1_dest_arch;
    xlen_t     s1_imm, s1_pc;

    // operand read -> dispatch
    logic      s2_valid, s2_eoi, s2_has_dest, s2_use_imm, s2_except;
    logic      s2_op1_rdy, s2_op2_rdy;
    uop_t      s2_uop;
    phys_tag_t s2_op1_tag, s2_op2_tag, s2_dest_tag, s2_old_tag;
    xlen_t     s2_op1_val, s2_op2_val;
    arch_reg_t s2_dest_arch;
    xlen_t     s2_imm, s2_pc;

    // committed old tags go straight back on the list
    free_list free_list_i (
        .push     (commit_valid),
        .push_tag (commit_tag),
        .*
    );

    rename_stage rename_i (.*);

    operand_read_stage operand_read_i (.*);

    dispatch_stage dispatch_i (.*);

endmodule

`default_nettype wire

// ==== operand_read_stage.sv ====
`default_nettype none

`include "mapper_defines.svh"

module operand_read_stage import mapper_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      s1_valid,
    input  wire uop_t      s1_uop,
    input  wire logic      s1_eoi,
    input  wire phys_tag_t s1_src1_tag,
    input  wire phys_tag_t s1_src2_tag,
    input  wire phys_tag_t s1_dest_tag,
    input  wire phys_tag_t s1_old_tag,
    input  wire arch_reg_t s1_dest_arch,
    input  wire logic      s1_has_dest,
    input  wire xlen_t     s1_imm,
    input  wire logic      s1_use_imm,
    input  wire xlen_t     s1_pc,
    input  wire logic      s1_except,
    input  wire logic      alloc_valid,
    input  wire phys_tag_t alloc_tag,
    input  wire logic      wb_valid,
    input  wire phys_tag_t wb_tag,
    input  wire xlen_t     wb_val,
    input  wire logic      hold,
    output logic           s2_valid,
    output logic           s2_op1_rdy,
    output logic           s2_op2_rdy,
    output phys_tag_t      s2_op1_tag,
    output phys_tag_t      s2_op2_tag,
    output xlen_t          s2_op1_val,
    output xlen_t          s2_op2_val,
    output uop_t           s2_uop,
    output logic           s2_eoi,
    output phys_tag_t      s2_dest_tag,
    output phys_tag_t      s2_old_tag,
    output arch_reg_t      s2_dest_arch,
    output logic           s2_has_dest,
    output xlen_t          s2_imm,
    output logic           s2_use_imm,
    output xlen_t          s2_pc,
    output logic           s2_except
);

    logic  rdy  [`MAPPER_PHYS_REGS];     // value present in the file
    xlen_t vals [`MAPPER_PHYS_REGS];

    logic  wb_hit1;
    logic  wb_hit2;
    logic  op1_rdy;
    logic  op2_rdy;
    xlen_t op1_val;
    xlen_t op2_val;

    // a result arriving this cycle bypasses the file
    assign wb_hit1 = wb_valid && (wb_tag == s1_src1_tag);
    assign wb_hit2 = wb_valid && (wb_tag == s1_src2_tag);
    assign op1_rdy = wb_hit1 || rdy[s1_src1_tag];
    assign op2_rdy = wb_hit2 || rdy[s1_src2_tag];
    assign op1_val = wb_hit1 ? wb_val : vals[s1_src1_tag];
    assign op2_val = wb_hit2 ? wb_val : vals[s1_src2_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MAPPER_PHYS_REGS; i++) begin
                rdy[i]  <= (i < `MAPPER_ARCH_REGS);   // identity-mapped tags hold zero
                vals[i] <= '0;
            end
        end else begin
            if (wb_valid) begin
                rdy[wb_tag]  <= 1'b1;
                vals[wb_tag] <= wb_val;
            end
            // allocation comes last so it beats a writeback to the same tag
            if (alloc_valid) begin
                rdy[alloc_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (!hold) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && s1_valid) begin
            s2_op1_rdy   <= op1_rdy;
            s2_op2_rdy   <= op2_rdy;
            s2_op1_tag   <= s1_src1_tag;
            s2_op2_tag   <= s1_src2_tag;
            s2_op1_val   <= op1_val;
            s2_op2_val   <= op2_val;
            s2_uop       <= s1_uop;
            s2_eoi       <= s1_eoi;
            s2_dest_tag  <= s1_dest_tag;
            s2_old_tag   <= s1_old_tag;
            s2_dest_arch <= s1_dest_arch;
            s2_has_dest  <= s1_has_dest;
            s2_imm       <= s1_imm;
            s2_use_imm   <= s1_use_imm;
            s2_pc        <= s1_pc;
            s2_except    <= s1_except;
        end
    end

endmodule

`default_nettype wire

// ==== rename_stage.sv ====
`default_nettype none

`include "mapper_defines.svh"

module rename_stage import mapper_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      uop_valid,
    input  wire uop_t      uop,
    input  wire logic      eoi,
    input  wire arch_reg_t src1_arch,
    input  wire arch_reg_t src2_arch,
    input  wire arch_reg_t dest_arch,
    input  wire logic      has_dest,
    input  wire xlen_t     imm,
    input  wire logic      use_imm,
    input  wire xlen_t     pc,
    input  wire logic      except,
    input  wire phys_tag_t free_tag,
    input  wire logic      free_empty,
    input  wire logic      hold,         // dispatch blocked by a full ROB
    output logic           pop,
    output logic           stall,
    output logic           alloc_valid,
    output phys_tag_t      alloc_tag,
    output logic           s1_valid,
    output uop_t           s1_uop,
    output logic           s1_eoi,
    output phys_tag_t      s1_src1_tag,
    output phys_tag_t      s1_src2_tag,
    output phys_tag_t      s1_dest_tag,
    output phys_tag_t      s1_old_tag,
    output arch_reg_t      s1_dest_arch,
    output logic           s1_has_dest,
    output xlen_t          s1_imm,
    output logic           s1_use_imm,
    output xlen_t          s1_pc,
    output logic           s1_except
);

    // speculative map, arch register -> physical tag
    phys_tag_t map_table [`MAPPER_ARCH_REGS];

    logic need_tag;
    logic accept;

    assign need_tag = uop_valid && has_dest;
    assign stall    = hold || (need_tag && free_empty);
    assign accept   = uop_valid && !stall;
    assign pop      = accept && has_dest;

    // the new tag is not ready until its producer writes back
    assign alloc_valid = pop;
    assign alloc_tag   = free_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MAPPER_ARCH_REGS; i++) begin
                map_table[i] <= phys_tag_t'(i);   // identity map
            end
        end else if (pop) begin
            map_table[dest_arch] <= free_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (!hold) begin
            s1_valid <= accept;
        end
    end

    // lookups read the table before this micro-op's own update lands
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_uop       <= uop;
            s1_eoi       <= eoi;
            s1_src1_tag  <= map_table[src1_arch];
            s1_src2_tag  <= map_table[src2_arch];
            s1_dest_tag  <= has_dest ? free_tag : '0;
            s1_old_tag   <= has_dest ? map_table[dest_arch] : '0;
            s1_dest_arch <= dest_arch;
            s1_has_dest  <= has_dest;
            s1_imm       <= imm;
            s1_use_imm   <= use_imm;
            s1_pc        <= pc;
            s1_except    <= except;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
mapper_pkg.sv
free_list.sv
rename_stage.sv
operand_read_stage.sv
dispatch_stage.sv
mapper_top.sv
tb_mapper.sv

// ==== tb_mapper_checks.svh ====
`ifndef TB_MAPPER_CHECKS_SVH
`define TB_MAPPER_CHECKS_SVH

// field compares, one task per result type
task automatic check_tag(input string test, what, input phys_tag_t exp, act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected %0d, actual %0d", test, what, exp, act);
        err_count++;
    end
endtask

task automatic check_val(input string test, what, input xlen_t exp, act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected 'h%08h, actual 'h%08h", test, what, exp, act);
        err_count++;
    end
endtask

task automatic check_bit(input string test, what, input logic exp, act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected %b, actual %b", test, what, exp, act);
        err_count++;
    end
endtask

task automatic check_rob(input string test, what, input rob_idx_t exp, act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected %0d, actual %0d", test, what, exp, act);
        err_count++;
    end
endtask

task automatic check_uop(input string test, what, input uop_t exp, act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected %0d, actual %0d", test, what, exp, act);
        err_count++;
    end
endtask

task automatic check_arch(input string test, what, input arch_reg_t exp, act);
    if (act !== exp) begin
        $display("Mismatch %s %s: expected %0d, actual %0d", test, what, exp, act);
        err_count++;
    end
endtask

`endif

// ==== tb_mapper.sv ====
`default_nettype none

`include "mapper_defines.svh"

module tb_mapper import mapper_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int N_RANDOM   = 60;

    // one table row is one clock cycle of stimulus
    typedef struct packed {
        logic      v, eoi, hd, ui, ex, wb, cm, full;
        uop_t      uop;
        arch_reg_t s1, s2, d;
        xlen_t     imm, pc, wbv;
        phys_tag_t wbt;
        rob_idx_t  rob;
    } row_t;

    // a micro-op in the model pipe
    typedef struct packed {
        logic      valid, eoi, hd, ui, ex, rdy1, rdy2;
        int        row;
        uop_t      uop;
        phys_tag_t src1, src2, dest, old;
        xlen_t     imm, pc, val1, val2;
        rob_idx_t  rob;
        arch_reg_t darch;
    } slot_t;

    logic      clk, reset, uop_valid, eoi, has_dest, use_imm, except;
    logic      wb_valid, commit_valid, rob_full, stall, disp_valid, eoi_out;
    logic      op1_rdy_out, op2_rdy_out, alloc_rob, except_out;
    uop_t      uop, uop_out;
    arch_reg_t src1_arch, src2_arch, dest_arch, dest_arch_out;
    phys_tag_t wb_tag, commit_tag, op1_tag_out, op2_tag_out, dest_tag_out, dest_oldtag_out;
    xlen_t     imm, pc, wb_val, op1_val_out, op2_val_out, pc_out;
    rob_idx_t  rob_entry_in, rob_entry_out;

    // reference model
    phys_tag_t m_map [`MAPPER_ARCH_REGS];
    logic      m_rdy [`MAPPER_PHYS_REGS];
    xlen_t     m_val [`MAPPER_PHYS_REGS];
    phys_tag_t m_free [$];
    phys_tag_t m_done_old [$];    // old tags of dispatched micro-ops, ready to commit
    slot_t     m1, m2, m3;

    row_t  rows [$];
    string names [$];
    int    row_err [$];
    int    err_count = 0;
    int    pending = 0;           // accepted, not yet dispatched
    int    n_rows = 0;

    `include "tb_mapper_checks.svh"

    mapper_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic row_t blank_row();
        row_t r;
        r = '0;
        r.uop = uop_t'(rows.size() * 7 + 3);
        r.eoi = (rows.size() % 3 == 0);
        r.pc  = 32'h1000 + 4 * rows.size();
        r.rob = rob_idx_t'(rows.size());
        return r;
    endfunction

    task automatic add_row(input string name, input row_t r);
        names.push_back(name);
        rows.push_back(r);
        row_err.push_back(0);
    endtask

    task automatic add_op(input string name, input arch_reg_t s1, s2, d, input logic hd);
        row_t r;
        r = blank_row();
        r.v  = 1'b1;
        r.s1 = s1;
        r.s2 = s2;
        r.d  = d;
        r.hd = hd;
        add_row(name, r);
    endtask

    task automatic add_bus(input string name, input logic wb, input phys_tag_t wbt,
                           input xlen_t wbv, input logic cm, full);
        row_t r;
        r = blank_row();
        r.wb   = wb;
        r.wbt  = wbt;
        r.wbv  = wbv;
        r.cm   = cm;
        r.full = full;
        add_row(name, r);
    endtask

    task automatic build_table();
        row_t r;
        add_op("ren_a", 2, 3, 1, 1);
        add_op("ren_b", 1, 4, 1, 1);          // reads tag 32 before its writeback
        add_op("ren_self", 5, 5, 5, 1);
        add_bus("wb_r1", 1, 33, 32'h1234, 0, 0);
        add_op("use_r1", 1, 0, 0, 0);
        add_op("fwd_a", 5, 9, 6, 1);
        add_bus("fwd_wb", 1, 34, 32'hbeef, 0, 0);  // stage 2 reads fwd_a here
        r = blank_row();
        r.v   = 1'b1;
        r.s1  = 6;
        r.s2  = 7;
        r.ui  = 1'b1;
        r.imm = 32'hcafe_f00d;
        r.ex  = 1'b1;
        add_row("imm_exc", r);
        add_op("no_dest", 7, 8, 0, 0);
        // three in flight, then the ROB fills up
        add_op("bp_a", 1, 2, 10, 1);
        add_op("bp_b", 10, 3, 11, 1);
        add_op("bp_c", 11, 10, 12, 1);
        for (int k = 0; k < 3; k++) begin
            add_bus($sformatf("bp_full_%0d", k), 0, 0, 0, 0, 1);
        end
        add_op("bp_d", 12, 0, 13, 1);
        // run the free list dry
        for (int k = 0; k < 30; k++) begin
            add_op($sformatf("fill_%0d", k), k, k + 1, 14 + k % 4, 1);
        end
        for (int k = 0; k < 3; k++) begin
            add_bus($sformatf("commit_%0d", k), 0, 0, 0, 1, 0);
        end
        for (int k = 0; k < 3; k++) begin
            add_op($sformatf("reuse_%0d", k), 14, 1, 20 + k, 1);
        end
        for (int k = 0; k < N_RANDOM; k++) begin
            r = blank_row();
            r.v    = $urandom_range(3) != 0;
            r.hd   = $urandom_range(3) != 0;
            r.ui   = $urandom_range(3) == 0;
            r.ex   = $urandom_range(7) == 0;
            r.s1   = arch_reg_t'($urandom);
            r.s2   = arch_reg_t'($urandom);
            r.d    = arch_reg_t'($urandom);
            r.imm  = $urandom;
            r.wb   = $urandom_range(2) == 0;
            r.wbt  = phys_tag_t'($urandom);
            r.wbv  = $urandom;
            r.cm   = $urandom_range(1) == 0;
            r.full = $urandom_range(5) == 0;
            add_row($sformatf("rand_%0d", k), r);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < `MAPPER_ARCH_REGS; i++) begin
            m_map[i] = phys_tag_t'(i);
        end
        for (int i = 0; i < `MAPPER_PHYS_REGS; i++) begin
            m_rdy[i] = (i < `MAPPER_ARCH_REGS);
            m_val[i] = '0;
            if (i >= `MAPPER_ARCH_REGS) m_free.push_back(phys_tag_t'(i));
        end
        m1 = '0;
        m2 = '0;
        m3 = '0;
    endtask

    task automatic report_row(input int idx);
        $display("%-12s %s", names[idx], (row_err[idx] == 0) ? "ok" : "failed");
    endtask

    task automatic check_dispatch(input slot_t s);
        string n;
        n = names[s.row];
        check_uop(n, "uop", s.uop, uop_out);
        check_bit(n, "eoi", s.eoi, eoi_out);
        check_bit(n, "op1_rdy", s.rdy1, op1_rdy_out);
        check_tag(n, "op1_tag", s.src1, op1_tag_out);
        if (s.rdy1) check_val(n, "op1_val", s.val1, op1_val_out);
        check_bit(n, "op2_rdy", s.rdy2, op2_rdy_out);
        if (!s.ui) check_tag(n, "op2_tag", s.src2, op2_tag_out);
        if (s.rdy2) check_val(n, "op2_val", s.val2, op2_val_out);
        check_tag(n, "dest_tag", s.dest, dest_tag_out);
        check_tag(n, "old_tag", s.old, dest_oldtag_out);
        check_arch(n, "dest_arch", s.darch, dest_arch_out);
        check_val(n, "pc", s.pc, pc_out);
        check_rob(n, "rob_entry", s.rob, rob_entry_out);
        check_bit(n, "alloc_rob", s.hd || s.ex, alloc_rob);
        check_bit(n, "except", s.ex, except_out);
    endtask

    // drive one row, check mid cycle, then step the model on the edge
    task automatic run_cycle(input row_t r, input int idx);
        slot_t     n1;
        slot_t     n2;
        slot_t     n3;
        logic      hold_m;
        logic      stall_m;
        logic      accept;
        logic      do_commit;
        phys_tag_t ctag;
        int        e0;
        string     tname;

        do_commit = r.cm && (m_done_old.size() > 0);
        ctag = '0;
        if (do_commit) ctag = m_done_old.pop_front();
        {uop_valid, uop, eoi, has_dest, use_imm, except} = {r.v, r.uop, r.eoi, r.hd, r.ui, r.ex};
        {src1_arch, src2_arch, dest_arch, imm, pc} = {r.s1, r.s2, r.d, r.imm, r.pc};
        {wb_valid, wb_tag, wb_val} = {r.wb, r.wbt, r.wbv};
        {commit_valid, commit_tag} = {do_commit, ctag};
        {rob_full, rob_entry_in} = {r.full, r.rob};
        #40;

        hold_m  = m3.valid && r.full;
        stall_m = hold_m || (r.v && r.hd && m_free.size() == 0);
        accept  = r.v && !stall_m;
        tname = "drain";
        if (idx >= 0) tname = names[idx];
        e0 = err_count;
        check_bit(tname, "stall", stall_m, stall);
        if (idx >= 0) row_err[idx] += err_count - e0;
        e0 = err_count;
        if (m3.valid) begin
            check_bit(names[m3.row], "disp_valid", 1'b1, disp_valid);
            check_dispatch(m3);
            row_err[m3.row] += err_count - e0;
            if (!hold_m) begin
                report_row(m3.row);
                pending--;
                if (m3.hd) m_done_old.push_back(m3.old);
            end
        end else begin
            check_bit(tname, "disp_valid", 1'b0, disp_valid);
            check_bit(tname, "alloc_rob", 1'b0, alloc_rob);
            if (idx >= 0) row_err[idx] += err_count - e0;
        end
        if (idx >= 0 && !accept) report_row(idx);

        @(posedge clk);
        if (!hold_m) begin
            n3 = m2;
            if (m2.ui) begin
                n3.rdy2 = 1'b1;         // immediate replaces source 2
                n3.val2 = m2.imm;
            end
            n3.rob = r.rob;
            n2 = m1;
            n2.rdy1 = (r.wb && r.wbt == m1.src1) || m_rdy[m1.src1];
            n2.val1 = (r.wb && r.wbt == m1.src1) ? r.wbv : m_val[m1.src1];
            n2.rdy2 = (r.wb && r.wbt == m1.src2) || m_rdy[m1.src2];
            n2.val2 = (r.wb && r.wbt == m1.src2) ? r.wbv : m_val[m1.src2];
            n1 = '0;
            {n1.valid, n1.row, n1.uop, n1.eoi} = {accept, idx, r.uop, r.eoi};
            {n1.hd, n1.ui, n1.ex, n1.imm, n1.pc} = {r.hd, r.ui, r.ex, r.imm, r.pc};
            n1.darch = r.d;
            n1.src1 = m_map[r.s1];      // sources see the map before this update
            n1.src2 = m_map[r.s2];
            if (r.hd && m_free.size() > 0) n1.dest = m_free[0];
            if (r.hd) n1.old = m_map[r.d];
            m3 = n3;
            m2 = n2;
            m1 = n1;
        end
        if (r.wb) begin
            m_rdy[r.wbt] = 1'b1;
            m_val[r.wbt] = r.wbv;
        end
        if (accept && r.hd) begin
            m_rdy[m_free[0]] = 1'b0;    // allocation beats a writeback
            m_map[r.d] = m_free.pop_front();
        end
        if (do_commit) m_free.push_back(ctag);
        if (accept) pending++;
        #5;
    endtask

    initial begin
        row_t idle;
        void'($urandom(32'ha47c));
        clk = 1'b0;
        reset = 1'b1;
        {uop_valid, eoi, has_dest, use_imm, except} = '0;
        {wb_valid, commit_valid, rob_full} = '0;
        {uop, src1_arch, src2_arch, dest_arch} = '0;
        {imm, pc, wb_val} = '0;
        {wb_tag, commit_tag, rob_entry_in} = '0;
        reset_model();
        build_table();
        n_rows = rows.size();
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;
        foreach (rows[i]) begin
            run_cycle(rows[i], i);
        end
        idle = blank_row();
        while (pending > 0) run_cycle(idle, -1);   // let the pipe empty out
        $display("%0d tests run, %0d checks failed", n_rows, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog, generous per row
    initial begin
        wait (n_rows > 0);
        #(n_rows * 20 * CLK_PERIOD);
        $display("timeout waiting for dispatch");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
